//--- core_pkg.sv
`default_nettype none

package core_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,
    pc_jal,
    pc_jalr
  } pc_sel_e;

  typedef struct packed {
    alu_op_e                alu_op;
    logic                   src_imm; // operand b from immediate
    logic                   src_pc;  // operand a from pc
    pc_sel_e                pc_sel;
    rv_isa_pkg::branch_f3_e branch_f3;
    rv_isa_pkg::reg_idx_t   rd;
    logic                   rf_we;
    logic                   halt;
    logic                   illegal;
  } dec_ctrl_t;

  // one retired instruction
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 we;
    rv_isa_pkg::word_t    wdata;
  } commit_t;

  typedef enum logic [1:0] {
    st_req,
    st_release,
    st_exec,
    st_halted
  } fetch_state_e;

endpackage

`default_nettype wire

//--- exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  logic                exec,
  input  rv_isa_pkg::word_t   pc,
  input  core_pkg::dec_ctrl_t ctrl,
  input  rv_isa_pkg::word_t   imm,
  input  rv_isa_pkg::word_t   rs1_data,
  input  rv_isa_pkg::word_t   rs2_data,
  output core_pkg::commit_t   commit,
  output rv_isa_pkg::word_t   next_pc,
  output logic                halt_req
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_y;
  word_t pc_plus4;
  word_t pc_target; // branch and jal target
  logic  taken;
  logic  is_jump;

  assign op_a      = ctrl.src_pc ? pc : rs1_data;
  assign op_b      = ctrl.src_imm ? imm : rs2_data;
  assign pc_plus4  = pc + word_t'(4);
  assign pc_target = pc + imm;
  assign is_jump   = ctrl.pc_sel == pc_jal || ctrl.pc_sel == pc_jalr;

  rv_alu alu_i (
    .op        (ctrl.alu_op),
    .a         (op_a),
    .b         (op_b),
    .y         (alu_y),
    .branch_f3 (ctrl.branch_f3),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .taken     (taken)
  );

  always_comb begin
    case (ctrl.pc_sel)
      pc_branch: next_pc = taken ? pc_target : pc_plus4;
      pc_jal:    next_pc = pc_target;
      pc_jalr:   next_pc = {alu_y[xlen-1:1], 1'b0}; // rs1 + imm, lsb cleared
      default:   next_pc = pc_plus4;
    endcase
  end

  assign commit.valid = exec;
  assign commit.pc    = pc;
  assign commit.rd    = ctrl.rd;
  assign commit.we    = ctrl.rf_we;
  assign commit.wdata = is_jump ? pc_plus4 : alu_y; // link address

  assign halt_req = ctrl.halt || ctrl.illegal;

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req,
  output rv_isa_pkg::word_t fetch_addr,
  input  logic              fetch_ack,
  input  rv_isa_pkg::word_t fetch_insn,
  output rv_isa_pkg::insn_t insn,
  output rv_isa_pkg::word_t pc,
  output logic              exec,
  input  rv_isa_pkg::word_t next_pc,
  input  logic              halt_req,
  output logic              halt
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  fetch_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_req;
      fetch_req <= 1'b0;
      pc        <= reset_pc;
    end else begin
      case (state)
        st_req: begin
          if (!fetch_req) begin
            fetch_req <= 1'b1; // first request after reset
          end else if (fetch_ack) begin
            fetch_req <= 1'b0;
            state     <= st_release;
          end
        end
        st_release: begin
          if (!fetch_ack) begin
            state <= st_exec; // memory has let go of ack
          end
        end
        st_exec: begin
          pc <= next_pc;
          if (halt_req) begin
            state <= st_halted;
          end else begin
            fetch_req <= 1'b1;
            state     <= st_req;
          end
        end
        default: begin
          state <= st_halted; // stuck until reset
        end
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == st_req && fetch_req && fetch_ack) begin
      insn <= insn_t'(fetch_insn);
    end
  end

  assign fetch_addr = pc;
  assign exec       = state == st_exec;
  assign halt       = state == st_halted;

  // four-phase rule, request is only withdrawn after the memory answered
  assert property (@(posedge clk) disable iff (rst) $fell(fetch_req) |-> $past(fetch_ack))
    else $error("fetch_req dropped before fetch_ack");

  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  core_pkg::commit_t    wr
);
  import rv_isa_pkg::*;

  word_t regs [32];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // writes aimed at x0 never show up on either read port
  assert property (@(posedge clk) disable iff (rst)
                   (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("x0 read back nonzero");

endmodule

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  core_pkg::alu_op_e      op,
  input  rv_isa_pkg::word_t      a,
  input  rv_isa_pkg::word_t      b,
  output rv_isa_pkg::word_t      y,
  input  rv_isa_pkg::branch_f3_e branch_f3,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  output logic                   taken
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [4:0] shamt;
  logic       lt_s; // branch compares, raw register values
  logic       lt_u;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sll:  y = a << shamt;
      alu_slt:  y = word_t'($signed(a) < $signed(b));
      alu_sltu: y = word_t'(a < b);
      alu_xor:  y = a ^ b;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = word_t'($signed(a) >>> shamt);
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      default:  y = b; // pass_b
    endcase
  end

  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (branch_f3)
      br_beq:  taken = rs1_data == rs2_data;
      br_bne:  taken = rs1_data != rs2_data;
      br_blt:  taken = lt_s;
      br_bge:  taken = !lt_s;
      br_bltu: taken = lt_u;
      br_bgeu: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req,
  output rv_isa_pkg::word_t fetch_addr,
  input  logic              fetch_ack,
  input  rv_isa_pkg::word_t fetch_insn,
  output core_pkg::commit_t commit,
  output logic              halt
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  insn_t     insn;
  word_t     pc;
  word_t     next_pc;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  dec_ctrl_t ctrl;
  logic      exec;
  logic      halt_req;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_insn (fetch_insn),
    .insn       (insn),
    .pc         (pc),
    .exec       (exec),
    .next_pc    (next_pc),
    .halt_req   (halt_req),
    .halt       (halt)
  );

  rv_decoder dec_i (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2)
  );

  // commit record doubles as the write port
  reg_file rf_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (commit)
  );

  exec_stage ex_i (
    .exec     (exec),
    .pc       (pc),
    .ctrl     (ctrl),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .commit   (commit),
    .next_pc  (next_pc),
    .halt_req (halt_req)
  );

endmodule

`default_nettype wire

//--- rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
  input logic              clk,
  input logic              rst,
  input logic              fetch_req,
  input rv_isa_pkg::word_t fetch_addr,
  input core_pkg::commit_t commit,
  input logic              halt
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  typedef struct packed {
    logic [3:0] test;
    word_t      pc;
    reg_idx_t   rd;
    logic       we;
    word_t      value;
  } expect_t;

  expect_t expected [$];
  string   names [1:6];
  int      checks [1:6] = '{default: 0};
  int      errs [1:6]   = '{default: 0};
  int      cur_test     = 1;
  int      n_commits    = 0;
  word_t   halt_pc      = '0;
  word_t   last_pc      = '0;
  logic    prev_req     = 1'b0;
  logic    first_fetch  = 1'b0;
  logic    halt_seen    = 1'b0;

  initial begin
    names[1] = "reset state";
    names[2] = "alu and x0";
    names[3] = "lui and auipc";
    names[4] = "branches";
    names[5] = "jal and jalr";
    names[6] = "ecall and halt";
  end

  task automatic push_expect(input logic [31:0] test, input logic [31:0] pc,
                             input logic [31:0] rd, input logic [31:0] we,
                             input logic [31:0] value);
    expect_t e;
    e.test  = test[3:0];
    e.pc    = pc;
    e.rd    = rd[4:0];
    e.we    = we[0];
    e.value = value;
    expected.push_back(e);
  endtask

  task automatic set_halt_pc(input word_t pc);
    halt_pc = pc;
  endtask

  task automatic compare_word(input int t, input string sig, input word_t exp, input word_t act);
    checks[t]++;
    if (exp !== act) begin
      errs[t]++;
      $display("Fail %s: expected 0x%08h, got 0x%08h", sig, exp, act);
    end
  endtask

  task automatic check_flag(input int t, input bit ok, input string what);
    checks[t]++;
    if (!ok) begin
      errs[t]++;
      $display("%s", what);
    end
  endtask

  task automatic close_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errs[t]);
  endtask

  // next fetch must go to the pc of the next expected commit
  task automatic check_fetch();
    expect_t e;
    first_fetch = 1'b1;
    if (n_commits < expected.size()) begin
      e = expected[n_commits];
      compare_word(cur_test, "fetch_addr", e.pc, fetch_addr);
    end else if (halt !== 1'b1) begin
      check_flag(cur_test, 1'b0, "fetch past the last expected instruction");
    end
  endtask

  task automatic check_commit();
    expect_t e;
    if (n_commits >= expected.size()) begin
      check_flag(6, 1'b0, $sformatf("unexpected commit at pc 0x%08h", commit.pc));
    end else begin
      e = expected[n_commits];
      while (cur_test < e.test) begin
        close_test(cur_test);
        cur_test++;
      end
      compare_word(cur_test, "commit.pc", e.pc, commit.pc);
      compare_word(cur_test, $sformatf("commit.we at pc %08h", e.pc), {31'b0, e.we},
                   {31'b0, commit.we});
      if (e.we) begin
        compare_word(cur_test, $sformatf("commit.rd at pc %08h", e.pc), {27'b0, e.rd},
                     {27'b0, commit.rd});
        compare_word(cur_test, $sformatf("commit.wdata at pc %08h", e.pc), e.value,
                     commit.wdata);
      end
    end
    n_commits++;
    last_pc = commit.pc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      prev_req = 1'b0;
    end else begin
      if (!first_fetch && fetch_req !== 1'b1) begin
        check_flag(1, commit.valid === 1'b0 && halt === 1'b0,
                   "commit.valid or halt high after reset");
      end
      if (fetch_req === 1'b1 && !prev_req) begin
        check_fetch();
      end
      if (commit.valid === 1'b1) begin
        check_commit();
      end
      if (halt_seen) begin
        check_flag(6, halt === 1'b1, "halt dropped without a reset");
        check_flag(6, fetch_req !== 1'b1, "fetch_req raised while halted");
      end
      if (halt === 1'b1) begin
        halt_seen = 1'b1;
      end
      prev_req = fetch_req;
    end
  end

  task automatic report(output int total_errors);
    int all_checks;
    all_checks   = 0;
    total_errors = 0;
    check_flag(6, halt_seen, "halt never rose");
    compare_word(6, "commit count", expected.size(), n_commits);
    compare_word(6, "halting pc", halt_pc, last_pc);
    while (cur_test <= 6) begin
      close_test(cur_test);
      cur_test++;
    end
    for (int t = 1; t <= 6; t++) begin
      all_checks   += checks[t];
      total_errors += errs[t];
    end
    $display("%0d checks, %0d errors", all_checks, total_errors);
  endtask

endmodule

`default_nettype wire

//--- rv_core_stimulus.txt
# i <byte address> <instruction word>
# c <test> <pc> <rd> <we> <wdata>, h <halting pc>, all fields hex
i 00000000 00500093
c 2 00000000 01 1 00000005
i 00000004 ffd00113
c 2 00000004 02 1 fffffffd
i 00000008 002081b3
c 2 00000008 03 1 00000002
i 0000000c 40208233
c 2 0000000c 04 1 00000008
i 00000010 001122b3
c 2 00000010 05 1 00000001
i 00000014 00113333
c 2 00000014 06 1 00000000
i 00000018 ffe12393
c 2 00000018 07 1 00000001
i 0000001c 0060b413
c 2 0000001c 08 1 00000001
i 00000020 0f014493
c 2 00000020 09 1 ffffff0d
i 00000024 0040e533
c 2 00000024 0a 1 0000000d
i 00000028 07f17593
c 2 00000028 0b 1 0000007d
i 0000002c 00409613
c 2 0000002c 0c 1 00000050
i 00000030 01c15693
c 2 00000030 0d 1 0000000f
i 00000034 40115713
c 2 00000034 0e 1 fffffffe
i 00000038 001097b3
c 2 00000038 0f 1 000000a0
i 0000003c 00708013
c 2 0000003c 00 1 0000000c
i 00000040 00100833
c 2 00000040 10 1 00000005
i 00000044 123458b7
c 3 00000044 11 1 12345000
i 00000048 00001917
c 3 00000048 12 1 00001048
i 0000004c 00208463
c 4 0000004c 00 0 00000000
i 00000050 00108463
c 4 00000050 00 0 00000000
i 00000058 00109463
c 4 00000058 00 0 00000000
i 0000005c 00209463
c 4 0000005c 00 0 00000000
i 00000064 0020c463
c 4 00000064 00 0 00000000
i 00000068 00114463
c 4 00000068 00 0 00000000
i 00000070 00115463
c 4 00000070 00 0 00000000
i 00000074 0020d463
c 4 00000074 00 0 00000000
i 0000007c 00116463
c 4 0000007c 00 0 00000000
i 00000080 0020e463
c 4 00000080 00 0 00000000
i 00000088 0020f463
c 4 00000088 00 0 00000000
i 0000008c 00117463
c 4 0000008c 00 0 00000000
i 00000094 00c009ef
c 5 00000094 13 1 00000098
i 000000a0 01598a67
c 5 000000a0 14 1 000000a4
i 000000ac 00000073
c 6 000000ac 00 0 00000000
h 000000ac

//--- rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::insn_t    insn,
  output core_pkg::dec_ctrl_t  ctrl,
  output rv_isa_pkg::word_t    imm,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::reg_idx_t rs2
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t   raw;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;
  alu_f3_e f3;
  logic    alt;      // funct7 picks sub / sra
  logic    f7_shift; // legal funct7 for a right shift

  function automatic alu_op_e alu_of(input alu_f3_e sel, input logic alt_sel);
    alu_op_e res;
    case (sel)
      f3_add_sub: res = alt_sel ? alu_sub : alu_add;
      f3_sll:     res = alu_sll;
      f3_slt:     res = alu_slt;
      f3_sltu:    res = alu_sltu;
      f3_xor:     res = alu_xor;
      f3_srl_sra: res = alt_sel ? alu_sra : alu_srl;
      f3_or:      res = alu_or;
      default:    res = alu_and;
    endcase
    return res;
  endfunction

  assign raw      = insn;
  assign rs1      = insn.rs1;
  assign rs2      = insn.rs2;
  assign f3       = alu_f3_e'(insn.funct3);
  assign alt      = insn.funct7 == funct7_alt;
  assign f7_shift = alt || insn.funct7 == funct7_base;

  // sign-extended immediates, one per format
  assign imm_i = {{20{raw[31]}}, raw[31:20]};
  assign imm_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};

  always_comb begin
    ctrl           = '0;
    ctrl.alu_op    = alu_add;
    ctrl.pc_sel    = pc_seq;
    ctrl.branch_f3 = branch_f3_e'(insn.funct3);
    ctrl.rd        = insn.rd;
    imm            = imm_i;
    case (opcode_e'(insn.opcode))
      opc_lui: begin
        imm          = imm_u;
        ctrl.src_imm = 1'b1;
        ctrl.alu_op  = alu_pass_b;
        ctrl.rf_we   = 1'b1;
      end
      opc_auipc: begin
        imm          = imm_u;
        ctrl.src_pc  = 1'b1;
        ctrl.src_imm = 1'b1;
        ctrl.rf_we   = 1'b1;
      end
      opc_jal: begin
        imm         = imm_j;
        ctrl.pc_sel = pc_jal;
        ctrl.rf_we  = 1'b1;
      end
      opc_jalr: begin
        ctrl.src_imm = 1'b1; // alu forms the target
        ctrl.pc_sel  = pc_jalr;
        ctrl.rf_we   = 1'b1;
        ctrl.illegal = insn.funct3 != 3'b000;
      end
      opc_branch: begin
        imm          = imm_b;
        ctrl.pc_sel  = pc_branch;
        ctrl.illegal = insn.funct3[2:1] == 2'b01;
      end
      opc_op_imm: begin
        ctrl.src_imm = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.alu_op  = alu_of(f3, alt && f3 == f3_srl_sra); // no subi
        if (f3 == f3_sll) begin
          ctrl.illegal = insn.funct7 != funct7_base;
        end else if (f3 == f3_srl_sra) begin
          ctrl.illegal = !f7_shift;
        end
      end
      opc_op: begin
        ctrl.rf_we   = 1'b1;
        ctrl.alu_op  = alu_of(f3, alt);
        ctrl.illegal = !(insn.funct7 == funct7_base ||
                         (alt && (f3 == f3_add_sub || f3 == f3_srl_sra)));
      end
      opc_system: begin
        ctrl.halt    = 1'b1;            // ecall
        ctrl.illegal = raw[31:7] != '0; // ebreak, csr ops
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // illegal retires as a plain halt
    if (ctrl.illegal) begin
      ctrl.halt   = 1'b1;
      ctrl.rf_we  = 1'b0;
      ctrl.pc_sel = pc_seq;
    end
  end

endmodule

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  parameter int xlen = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  // major opcodes this core executes, everything else is illegal
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_f3_e;

  typedef enum logic [2:0] {
    f3_add_sub = 3'b000,
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } alu_f3_e;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra, srai

  // r-type field layout, other formats reuse the same bits
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } insn_t;

endpackage

`default_nettype wire

//--- src.f
rv_isa_pkg.sv
core_pkg.sv
rv_alu.sv
rv_decoder.sv
reg_file.sv
exec_stage.sv
fetch_unit.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam int fetch_timeout = 50;   // cycles per handshake phase
  localparam int run_timeout   = 5000;

  logic    clk;
  logic    rst;
  logic    fetch_req;
  word_t   fetch_addr;
  logic    fetch_ack;
  word_t   fetch_insn;
  commit_t commit;
  logic    halt;

  word_t   mem [256];
  logic    hung;     // responder gave up on a handshake
  logic    load_ok;
  int      errors;
  int      waited;
  int      seed_val;

  rv_core #(
    .reset_pc (32'h0000_0000)
  ) rv_core_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_ack  (fetch_ack),
    .fetch_insn (fetch_insn),
    .commit     (commit),
    .halt       (halt)
  );

  rv_core_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .commit     (commit),
    .halt       (halt)
  );

  always #5 clk = ~clk;

  task automatic fill_memory();
    for (int k = 0; k < 256; k++) begin
      mem[k] = 32'hbad0_0000 | (k << 2); // low bits 00 never form a legal opcode
    end
  endtask

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    ok = 1'b0;
    fd = $fopen("rv_core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open rv_core_stimulus.txt");
    end else begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        tag = " ";
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h", tag, a, b, c, d, e);
        end
        case (tag)
          "i": mem[a[9:2]] = b;
          "c": checker_i.push_expect(a, b, c, d, e); // test, pc, rd, we, wdata
          "h": checker_i.set_halt_pc(a);
          default: ;
        endcase
      end
      $fclose(fd);
    end
  endtask

  // instruction memory side of the four-phase fetch
  task automatic serve_fetches();
    int delay;
    int cnt;
    bit done;
    done = 1'b0;
    while (!done) begin
      cnt = 0;
      while (fetch_req !== 1'b1 && halt !== 1'b1 && cnt < fetch_timeout) begin
        @(posedge clk);
        #1;
        cnt++;
      end
      if (halt === 1'b1) begin
        done = 1'b1;
      end else if (fetch_req !== 1'b1) begin
        $display("no fetch_req from the core within %0d cycles", fetch_timeout);
        hung = 1'b1;
        done = 1'b1;
      end else begin
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        fetch_insn = mem[fetch_addr[9:2]];
        fetch_ack  = 1'b1;
        cnt = 0;
        while (fetch_req === 1'b1 && cnt < fetch_timeout) begin
          @(posedge clk);
          #1;
          cnt++;
        end
        if (fetch_req === 1'b1) begin
          $display("fetch_req still high %0d cycles after fetch_ack", fetch_timeout);
          hung = 1'b1;
          done = 1'b1;
        end else begin
          delay = $urandom_range(3, 0);
          repeat (delay) begin
            @(posedge clk);
            #1;
          end
          fetch_ack  = 1'b0;
          fetch_insn = '0;
        end
      end
    end
  endtask

  initial begin
    seed_val   = $urandom(32'h8da1_4f95);
    clk        = 1'b0;
    rst        = 1'b1;
    fetch_ack  = 1'b0;
    fetch_insn = '0;
    hung       = 1'b0;
    errors     = 0;
    fill_memory();
    load_stimulus(load_ok);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    if (load_ok) begin
      fork
        serve_fetches();
      join_none
      waited = 0;
      while (halt !== 1'b1 && !hung && waited < run_timeout) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (halt === 1'b1) begin
        repeat (20) @(posedge clk); // halt must hold with no new fetch
        #1;
      end else if (!hung) begin
        $display("halt did not rise within %0d cycles", run_timeout);
      end
    end
    checker_i.report(errors);
    if (errors == 0 && load_ok && !hung && halt === 1'b1) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
